//--- Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal -j 0
TOP = memsys_tb
FILELIST = build.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- build.f
+incdir+src
src/memsys_pkg.sv
src/icache.sv
src/dcache.sv
src/main_memory.sv
src/refill_ctrl.sv
src/memsys_top.sv
tests/memsys_props.sv
tests/memsys_tb.sv

//--- src/dcache.sv
`include "memsys_macros.svh"

module dcache import memsys_pkg::*; (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    i_read,
	input  logic                    i_write,
	input  logic [`WORD_SIZE-1:0]   i_addr,
	input  logic [`WORD_SIZE-1:0]   i_wdata,
	input  logic                    i_fill_we,
	input  logic [`OFFSET_BITS-1:0] i_fill_offset,
	input  logic [`WORD_SIZE-1:0]   i_fill_data,
	input  logic                    i_fill_done,
	input  logic [`OFFSET_BITS-1:0] i_evict_offset,
	output logic [`WORD_SIZE-1:0]   o_rdata,
	output logic                    o_busy,
	output logic                    o_miss,
	output logic                    o_victim_dirty,
	output logic [`TAG_BITS-1:0]    o_victim_tag,
	output logic [`WORD_SIZE-1:0]   o_evict_data
);

	mem_addr_u addr;
	logic [`TAG_BITS-1:0] tags [`LINE_COUNT];
	logic [`WORD_SIZE-1:0] lines [`LINE_COUNT][`LINE_WORDS];
	logic [`LINE_COUNT-1:0] valid;
	logic [`LINE_COUNT-1:0] dirty;
	logic hit;
	logic req;

	assign addr = i_addr;
	assign req = i_read || i_write;
	assign hit = valid[addr.cache.index] && (tags[addr.cache.index] == addr.cache.tag);

	assign o_miss = req && !hit;
	assign o_busy = o_miss;

	// victim side of the indexed line, read by the controller for write-back
	assign o_victim_dirty = valid[addr.cache.index] && dirty[addr.cache.index];
	assign o_victim_tag = tags[addr.cache.index];
	assign o_evict_data = lines[addr.cache.index][i_evict_offset];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_fill_done) begin
			valid[addr.cache.index] <= 1'b1;
			dirty[addr.cache.index] <= 1'b0;
		end else if (i_write && hit) begin
			dirty[addr.cache.index] <= 1'b1;
		end
	end

	// a write hit and a fill never overlap, a filling line is still a miss
	always_ff @(posedge clk) begin
		if (i_fill_we) begin
			lines[addr.cache.index][i_fill_offset] <= i_fill_data;
		end else if (i_write && hit) begin
			lines[addr.cache.index][addr.cache.offset] <= i_wdata;
		end
		if (i_fill_done) begin
			tags[addr.cache.index] <= addr.cache.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (i_read && hit) begin
			o_rdata <= lines[addr.cache.index][addr.cache.offset];
		end
	end

endmodule

//--- src/icache.sv
`include "memsys_macros.svh"

module icache import memsys_pkg::*; (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    i_read,
	input  logic [`WORD_SIZE-1:0]   i_addr,
	input  logic                    i_fill_we,
	input  logic [`OFFSET_BITS-1:0] i_fill_offset,
	input  logic [`WORD_SIZE-1:0]   i_fill_data,
	input  logic                    i_fill_done,
	output logic [`WORD_SIZE-1:0]   o_data,
	output logic                    o_busy,
	output logic                    o_miss
);

	mem_addr_u addr;
	logic [`TAG_BITS-1:0] tags [`LINE_COUNT];
	logic [`WORD_SIZE-1:0] lines [`LINE_COUNT][`LINE_WORDS];
	logic [`LINE_COUNT-1:0] valid;
	logic hit;

	assign addr = i_addr;
	assign hit = valid[addr.cache.index] && (tags[addr.cache.index] == addr.cache.tag);

	// no separate refill flag, the line stays a miss until the fill completes
	assign o_miss = i_read && !hit;
	assign o_busy = o_miss;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid <= '0;
		end else if (i_fill_done) begin
			valid[addr.cache.index] <= 1'b1;
		end
	end

	// fill words land in the line selected by the held request address
	always_ff @(posedge clk) begin
		if (i_fill_we) begin
			lines[addr.cache.index][i_fill_offset] <= i_fill_data;
		end
		if (i_fill_done) begin
			tags[addr.cache.index] <= addr.cache.tag;
		end
	end

	// read data shows up one edge after the hit
	always_ff @(posedge clk) begin
		if (i_read && hit) begin
			o_data <= lines[addr.cache.index][addr.cache.offset];
		end
	end

endmodule

//--- src/main_memory.sv
`include "memsys_macros.svh"

module main_memory (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic [`WORD_SIZE-1:0] i_addr,
	input  logic                  i_we,
	input  logic [`WORD_SIZE-1:0] i_wdata,
	output logic [`WORD_SIZE-1:0] o_rdata
);

	localparam int ADDR_W = $clog2(`MEM_WORDS);

	logic [`WORD_SIZE-1:0] mem [`MEM_WORDS];
	logic [ADDR_W-1:0] word_addr;

	// upper address bits fold away
	assign word_addr = i_addr[ADDR_W-1:0];

	// reset sweeps every word back to zero
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int sweep = 0; sweep < `MEM_WORDS; sweep++) begin
				mem[sweep] <= '0;
			end
		end else if (i_we) begin
			mem[word_addr] <= i_wdata;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk) begin
		o_rdata <= mem[word_addr];
	end

endmodule

//--- src/memsys_macros.svh
`ifndef MEMSYS_MACROS_SVH
`define MEMSYS_MACROS_SVH

// data and address width
`define WORD_SIZE 16

// backing store depth, addresses fold modulo this
`define MEM_WORDS 256

// direct-mapped cache geometry
`define LINE_COUNT 8
`define LINE_WORDS 4
`define TAG_BITS 11
`define INDEX_BITS 3
`define OFFSET_BITS 2

// fixed wait before each line transfer
`define MEM_DELAY 5

`endif

//--- src/memsys_pkg.sv
`include "memsys_macros.svh"

package memsys_pkg;

	// one address word, split for the cache lookup or for memory line access
	typedef union packed {
		struct packed {
			logic [`TAG_BITS-1:0] tag;
			logic [`INDEX_BITS-1:0] index;
			logic [`OFFSET_BITS-1:0] offset;
		} cache;
		struct packed {
			logic [`TAG_BITS+`INDEX_BITS-1:0] line;
			logic [`OFFSET_BITS-1:0] offset;
		} mem;
	} mem_addr_u;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_WB,
		WRITE_BACK,
		WAIT_FILL,
		FILL
	} ctrl_state_e;

endpackage

//--- src/memsys_top.sv
`include "memsys_macros.svh"

module memsys_top (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  i_i_read,
	input  logic [`WORD_SIZE-1:0] i_i_addr,
	output logic [`WORD_SIZE-1:0] o_i_data,
	output logic                  o_i_busy,
	input  logic                  i_d_read,
	input  logic                  i_d_write,
	input  logic [`WORD_SIZE-1:0] i_d_addr,
	input  logic [`WORD_SIZE-1:0] i_d_wdata,
	output logic [`WORD_SIZE-1:0] o_d_rdata,
	output logic                  o_d_busy
);

	logic i_miss, d_miss, d_victim_dirty;
	logic [`TAG_BITS-1:0] d_victim_tag;
	logic i_fill_we, d_fill_we, i_fill_done, d_fill_done;
	logic [`OFFSET_BITS-1:0] fill_offset, evict_offset;
	logic [`WORD_SIZE-1:0] fill_data, evict_data;
	logic [`WORD_SIZE-1:0] mem_addr, mem_wdata, mem_rdata;
	logic mem_we;

	icache u_icache (
		.clk(clk), .reset_n(reset_n), .i_read(i_i_read), .i_addr(i_i_addr),
		.i_fill_we(i_fill_we), .i_fill_offset(fill_offset), .i_fill_data(fill_data),
		.i_fill_done(i_fill_done), .o_data(o_i_data), .o_busy(o_i_busy), .o_miss(i_miss)
	);

	dcache u_dcache (
		.clk(clk), .reset_n(reset_n), .i_read(i_d_read), .i_write(i_d_write),
		.i_addr(i_d_addr), .i_wdata(i_d_wdata), .i_fill_we(d_fill_we),
		.i_fill_offset(fill_offset), .i_fill_data(fill_data), .i_fill_done(d_fill_done),
		.i_evict_offset(evict_offset), .o_rdata(o_d_rdata), .o_busy(o_d_busy),
		.o_miss(d_miss), .o_victim_dirty(d_victim_dirty), .o_victim_tag(d_victim_tag),
		.o_evict_data(evict_data)
	);

	refill_ctrl u_refill_ctrl (
		.clk(clk), .reset_n(reset_n), .i_i_miss(i_miss), .i_i_addr(i_i_addr),
		.i_d_miss(d_miss), .i_d_addr(i_d_addr), .i_d_victim_dirty(d_victim_dirty),
		.i_d_victim_tag(d_victim_tag), .i_evict_data(evict_data), .i_mem_rdata(mem_rdata),
		.o_i_fill_we(i_fill_we), .o_d_fill_we(d_fill_we), .o_fill_offset(fill_offset),
		.o_fill_data(fill_data), .o_i_fill_done(i_fill_done), .o_d_fill_done(d_fill_done),
		.o_evict_offset(evict_offset), .o_mem_addr(mem_addr), .o_mem_we(mem_we),
		.o_mem_wdata(mem_wdata)
	);

	main_memory u_main_memory (
		.clk(clk), .reset_n(reset_n), .i_addr(mem_addr), .i_we(mem_we),
		.i_wdata(mem_wdata), .o_rdata(mem_rdata)
	);

endmodule

//--- src/refill_ctrl.sv
`include "memsys_macros.svh"

module refill_ctrl import memsys_pkg::*; (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    i_i_miss,
	input  logic [`WORD_SIZE-1:0]   i_i_addr,
	input  logic                    i_d_miss,
	input  logic [`WORD_SIZE-1:0]   i_d_addr,
	input  logic                    i_d_victim_dirty,
	input  logic [`TAG_BITS-1:0]    i_d_victim_tag,
	input  logic [`WORD_SIZE-1:0]   i_evict_data,
	input  logic [`WORD_SIZE-1:0]   i_mem_rdata,
	output logic                    o_i_fill_we,
	output logic                    o_d_fill_we,
	output logic [`OFFSET_BITS-1:0] o_fill_offset,
	output logic [`WORD_SIZE-1:0]   o_fill_data,
	output logic                    o_i_fill_done,
	output logic                    o_d_fill_done,
	output logic [`OFFSET_BITS-1:0] o_evict_offset,
	output logic [`WORD_SIZE-1:0]   o_mem_addr,
	output logic                    o_mem_we,
	output logic [`WORD_SIZE-1:0]   o_mem_wdata
);

	localparam int CNT_W = $clog2(`MEM_DELAY + `LINE_WORDS);

	ctrl_state_e state;
	logic [CNT_W-1:0] cnt;
	logic sel_d;
	logic [`TAG_BITS+`INDEX_BITS-1:0] line_q;
	logic [`TAG_BITS-1:0] vtag_q;
	mem_addr_u i_a, d_a, fill_addr, wb_addr;
	logic fill_active, fill_last;

	assign i_a = i_i_addr;
	assign d_a = i_d_addr;

	// refill reads the new line; write-back swaps in the victim tag, same index
	always_comb begin
		fill_addr.mem.line = line_q;
		fill_addr.mem.offset = cnt[`OFFSET_BITS-1:0];
		wb_addr = fill_addr;
		wb_addr.cache.tag = vtag_q;
	end

	assign o_mem_addr = (state == WRITE_BACK) ? wb_addr : fill_addr;
	assign o_mem_we = (state == WRITE_BACK);
	assign o_mem_wdata = i_evict_data;
	assign o_evict_offset = cnt[`OFFSET_BITS-1:0];

	// fill port trails the memory address by one cycle
	assign fill_active = (state == FILL) && (cnt != '0);
	assign fill_last = (state == FILL) && (cnt == CNT_W'(`LINE_WORDS));
	assign o_fill_offset = `OFFSET_BITS'(cnt - 1'b1);
	assign o_fill_data = i_mem_rdata;
	assign o_i_fill_we = fill_active && !sel_d;
	assign o_d_fill_we = fill_active && sel_d;
	assign o_i_fill_done = fill_last && !sel_d;
	assign o_d_fill_done = fill_last && sel_d;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			cnt <= '0;
			sel_d <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					cnt <= '0;
					// data port wins a tie
					if (i_d_miss) begin
						sel_d <= 1'b1;
						state <= i_d_victim_dirty ? WAIT_WB : WAIT_FILL;
					end else if (i_i_miss) begin
						sel_d <= 1'b0;
						state <= WAIT_FILL;
					end
				end
				WAIT_WB, WAIT_FILL: begin
					if (cnt == CNT_W'(`MEM_DELAY - 1)) begin
						cnt <= '0;
						state <= (state == WAIT_WB) ? WRITE_BACK : FILL;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				WRITE_BACK: begin
					if (cnt == CNT_W'(`LINE_WORDS - 1)) begin
						cnt <= '0;
						state <= WAIT_FILL;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				FILL: begin
					if (fill_last) begin
						cnt <= '0;
						state <= IDLE;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			line_q <= i_d_miss ? d_a.mem.line : i_a.mem.line;
			vtag_q <= i_d_victim_tag;
		end
	end

endmodule

//--- tests/memsys_cases.txt
// port: 0 instruction, 1 data; op: 0 read, 1 write, 2 read issued with the next line
// then address, and write data or expected read data, all hex
0 0 0010 0000
1 0 0024 0000
1 1 0048 beef
1 0 0048 beef
1 1 0062 3333
1 0 0061 0000
1 1 0060 1111
1 1 0061 2222
1 1 0063 4444
1 0 0060 1111
1 0 0061 2222
1 0 0062 3333
1 0 0063 4444
1 0 0088 0000
0 0 0048 beef
1 2 00a0 0000
0 0 0063 4444
1 2 0049 0000
0 0 0030 0000

//--- tests/memsys_props.sv
`include "memsys_macros.svh"

module memsys_props import memsys_pkg::*; (
	input logic                  clk,
	input logic                  reset_n,
	input logic                  i_i_read,
	input logic [`WORD_SIZE-1:0] i_i_addr,
	input logic                  i_i_busy,
	input logic                  i_d_read,
	input logic                  i_d_write,
	input logic [`WORD_SIZE-1:0] i_d_addr,
	input logic [`WORD_SIZE-1:0] i_d_wdata,
	input logic                  i_d_busy,
	input logic                  i_i_fill_we,
	input logic                  i_d_fill_we,
	input logic                  i_i_fill_done,
	input logic                  i_d_fill_done,
	input logic                  i_mem_we,
	input ctrl_state_e           i_state
);
	timeunit 1ns;
	timeprecision 1ns;

	// a reset edge leaves the controller idle with every strobe low
	reset_quiet: assert property (@(posedge clk)
		!reset_n |=> (i_state == IDLE && !i_i_fill_we && !i_d_fill_we && !i_mem_we))
		else $error("controller active or strobe high after a reset edge");

	// once the line lands, the held request finishes with busy low
	i_fill_completes: assert property (@(posedge clk) disable iff (!reset_n)
		(i_i_fill_done && i_i_read) |=> !i_i_busy)
		else $error("instruction busy still high after its fill");
	d_fill_completes: assert property (@(posedge clk) disable iff (!reset_n)
		(i_d_fill_done && (i_d_read || i_d_write)) |=> !i_d_busy)
		else $error("data busy still high after its fill");

	i_req_held: assert property (@(posedge clk) disable iff (!reset_n)
		i_i_busy |=> (i_i_read && $stable(i_i_addr)))
		else $error("instruction request dropped or changed while busy");
	d_req_held: assert property (@(posedge clk) disable iff (!reset_n)
		i_d_busy |=> ((i_d_read || i_d_write) && $stable(i_d_addr) && $stable(i_d_wdata)))
		else $error("data request dropped or changed while busy");

endmodule

bind memsys_top memsys_props u_props (
	.clk(clk), .reset_n(reset_n), .i_i_read(i_i_read), .i_i_addr(i_i_addr),
	.i_i_busy(o_i_busy), .i_d_read(i_d_read), .i_d_write(i_d_write), .i_d_addr(i_d_addr),
	.i_d_wdata(i_d_wdata), .i_d_busy(o_d_busy), .i_i_fill_we(i_fill_we),
	.i_d_fill_we(d_fill_we), .i_i_fill_done(i_fill_done), .i_d_fill_done(d_fill_done),
	.i_mem_we(mem_we), .i_state(u_refill_ctrl.state)
);

//--- tests/memsys_tb.sv
`include "memsys_macros.svh"

module memsys_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int MAX_CASES = 32;
	localparam int TIMEOUT = 200;
	localparam logic [15:0] END_MARK = 16'hffff;
	localparam int CLEAN_MISS = `MEM_DELAY + `LINE_WORDS + 2;
	localparam int DIRTY_EXTRA = `MEM_DELAY + `LINE_WORDS;

	logic clk;
	logic reset_n;
	logic i_read;
	logic [`WORD_SIZE-1:0] i_addr;
	logic [`WORD_SIZE-1:0] i_data;
	logic i_busy;
	logic d_read;
	logic d_write;
	logic [`WORD_SIZE-1:0] d_addr;
	logic [`WORD_SIZE-1:0] d_wdata;
	logic [`WORD_SIZE-1:0] d_rdata;
	logic d_busy;

	// four words per case: port, op, address, data
	logic [15:0] case_words [MAX_CASES*4];
	int errors;
	int tests;
	int failed_tests;
	bit timed_out;

	// expected tag state of both caches
	logic [`TAG_BITS-1:0] model_i_tag [`LINE_COUNT];
	logic [`TAG_BITS-1:0] model_d_tag [`LINE_COUNT];
	logic [`LINE_COUNT-1:0] model_i_valid;
	logic [`LINE_COUNT-1:0] model_d_valid;
	logic [`LINE_COUNT-1:0] model_d_dirty;

	memsys_top DUT (
		.clk(clk), .reset_n(reset_n), .i_i_read(i_read), .i_i_addr(i_addr),
		.o_i_data(i_data), .o_i_busy(i_busy), .i_d_read(d_read), .i_d_write(d_write),
		.i_d_addr(d_addr), .i_d_wdata(d_wdata), .o_d_rdata(d_rdata), .o_d_busy(d_busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got %h, expected %h", name, actual, expected);
			errors++;
		end
	endtask

	// expected busy edges of one access; a hit costs none, the model keeps the new line
	task automatic icache_busy_edges(input logic [15:0] addr, output int edges);
		logic [`INDEX_BITS-1:0] idx;
		logic [`TAG_BITS-1:0] tag;
		idx = addr[`OFFSET_BITS +: `INDEX_BITS];
		tag = addr[`WORD_SIZE-1 -: `TAG_BITS];
		edges = 0;
		if (!(model_i_valid[idx] && model_i_tag[idx] == tag)) begin
			edges = CLEAN_MISS;
			model_i_valid[idx] = 1'b1;
			model_i_tag[idx] = tag;
		end
	endtask

	task automatic dcache_busy_edges(input logic [15:0] addr, input bit write,
			output int edges);
		logic [`INDEX_BITS-1:0] idx;
		logic [`TAG_BITS-1:0] tag;
		idx = addr[`OFFSET_BITS +: `INDEX_BITS];
		tag = addr[`WORD_SIZE-1 -: `TAG_BITS];
		edges = 0;
		if (!(model_d_valid[idx] && model_d_tag[idx] == tag)) begin
			edges = CLEAN_MISS;
			// a dirty victim goes back to memory first
			if (model_d_dirty[idx])
				edges += DIRTY_EXTRA;
			model_d_valid[idx] = 1'b1;
			model_d_tag[idx] = tag;
			model_d_dirty[idx] = 1'b0;
		end
		if (write)
			model_d_dirty[idx] = 1'b1;
	endtask

	// busy is sampled on falling edges, away from the register updates
	task automatic wait_ready(input bit want_i, input bit want_d, output bit ok,
			output int i_wait, output int d_wait);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		i_wait = 0;
		d_wait = 0;
		while (!ok && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
			if (want_i && i_wait == 0 && !i_busy)
				i_wait = cycles;
			if (want_d && d_wait == 0 && !d_busy)
				d_wait = cycles;
			ok = (!want_i || i_wait != 0) && (!want_d || d_wait != 0);
		end
	endtask

	task automatic drive_request(input int n);
		if (case_words[4*n] == 16'd0) begin
			i_read = 1'b1;
			i_addr = case_words[4*n+2];
		end else begin
			d_read = (case_words[4*n+1] != 16'd1);
			d_write = (case_words[4*n+1] == 16'd1);
			d_addr = case_words[4*n+2];
			d_wdata = case_words[4*n+3];
		end
	endtask

	task automatic run_test(input int first, input int count);
		int n;
		int errs_at_start;
		int i_edges;
		int d_edges;
		int i_wait;
		int d_wait;
		bit want_i;
		bit want_d;
		bit ok;
		errs_at_start = errors;
		want_i = 1'b0;
		want_d = 1'b0;
		i_edges = 0;
		d_edges = 0;
		@(negedge clk);
		for (n = first; n < first + count; n++) begin
			drive_request(n);
			if (case_words[4*n] == 16'd0) begin
				want_i = 1'b1;
				icache_busy_edges(case_words[4*n+2], i_edges);
			end else begin
				want_d = 1'b1;
				dcache_busy_edges(case_words[4*n+2], case_words[4*n+1] == 16'd1, d_edges);
			end
		end
		// data wins a tie, so an instruction miss also sits out the data service
		if (i_edges != 0 && d_edges != 0)
			i_edges += d_edges;
		wait_ready(want_i, want_d, ok, i_wait, d_wait);
		// one more falling edge puts the completing edge behind us
		@(negedge clk);
		if (!ok) begin
			$display("busy stayed high for %0d cycles at case line %0d", TIMEOUT, first + 1);
			errors++;
			timed_out = 1'b1;
		end else begin
			// a hit already reads as ready at the first falling edge
			if (want_i)
				check_value("o_i_busy", 16'(i_wait), 16'((i_edges == 0) ? 1 : i_edges));
			if (want_d)
				check_value("o_d_busy", 16'(d_wait), 16'((d_edges == 0) ? 1 : d_edges));
			for (n = first; n < first + count; n++) begin
				if (case_words[4*n+1] != 16'd1 && case_words[4*n] == 16'd0)
					check_value("o_i_data", i_data, case_words[4*n+3]);
				else if (case_words[4*n+1] != 16'd1)
					check_value("o_d_rdata", d_rdata, case_words[4*n+3]);
			end
		end
		i_read = 1'b0;
		d_read = 1'b0;
		d_write = 1'b0;
		tests++;
		if (errors != errs_at_start)
			failed_tests++;
		$display("test %0d (case line %0d, addr %h): %s", tests, first + 1,
			case_words[4*first+2], (errors == errs_at_start) ? "ok" : "error");
	endtask

	initial begin
		int k;
		int w;
		reset_n = 1'b0;
		i_read = 1'b0;
		i_addr = '0;
		d_read = 1'b0;
		d_write = 1'b0;
		d_addr = '0;
		d_wdata = '0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		timed_out = 1'b0;
		model_i_valid = '0;
		model_d_valid = '0;
		model_d_dirty = '0;
		for (w = 0; w < MAX_CASES * 4; w++)
			case_words[w] = END_MARK;
		$readmemh("tests/memsys_cases.txt", case_words);
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		k = 0;
		while (k < MAX_CASES && case_words[4*k] != END_MARK && !timed_out) begin
			// op 2 pairs a read with the next line's read
			if (case_words[4*k+1] == 16'd2 && k + 1 < MAX_CASES) begin
				run_test(k, 2);
				k += 2;
			end else begin
				run_test(k, 1);
				k += 1;
			end
		end
		if (tests == 0) begin
			$display("no cases were read from tests/memsys_cases.txt");
			errors++;
		end
		$display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
